// File: source/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
  input logic clock,
  input logic reset,
  mem_bus_if.slave cpu,
  mem_bus_if.master bram,
  mem_bus_if.master print,
  mem_bus_if.master clint
);

  import soc_pkg::*;

  logic in_clint;
  logic in_print;
  logic in_bram;
  logic bad_request;  // unmapped, or a fetch outside the ram
  logic error_ready;
  logic [addr_width-1:0] base_addr;
  logic [addr_width-1:0] local_addr;

  always_comb begin
    in_clint = (cpu.addr >= clint_base_addr) && (cpu.addr < clint_top_addr);
    in_print = (cpu.addr >= print_base_addr) && (cpu.addr < print_top_addr);
    in_bram = (cpu.addr >= bram_base_addr) && (cpu.addr < bram_top_addr);
  end

  always_comb begin
    bram.valid = 1'b0;
    print.valid = 1'b0;
    clint.valid = 1'b0;
    base_addr = '0;
    bad_request = cpu.valid;
    if (in_clint) begin
      clint.valid = cpu.valid && !cpu.instr;
      base_addr = clint_base_addr;
      bad_request = cpu.valid && cpu.instr;
    end else if (in_print) begin
      print.valid = cpu.valid && !cpu.instr;
      base_addr = print_base_addr;
      bad_request = cpu.valid && cpu.instr;
    end else if (in_bram) begin
      bram.valid = cpu.valid;
      base_addr = bram_base_addr;
      bad_request = 1'b0;
    end
  end

  assign local_addr = cpu.addr - base_addr;  // rebase into the slave window

  assign bram.addr = local_addr;
  assign bram.wdata = cpu.wdata;
  assign bram.wstrb = cpu.wstrb;
  assign print.addr = local_addr;
  assign print.wdata = cpu.wdata;
  assign print.wstrb = cpu.wstrb;
  assign clint.addr = local_addr;
  assign clint.wdata = cpu.wdata;
  assign clint.wstrb = cpu.wstrb;

  // one error pulse per bad request, same timing as a slave
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= bad_request && !error_ready;
    end
  end

  always_comb begin
    cpu.rdata = '0;
    cpu.error = 1'b0;
    cpu.ready = 1'b0;
    if (bram.ready) begin
      cpu.rdata = bram.rdata;
      cpu.error = bram.error;
      cpu.ready = 1'b1;
    end else if (print.ready) begin
      cpu.rdata = print.rdata;
      cpu.error = print.error;
      cpu.ready = 1'b1;
    end else if (clint.ready) begin
      cpu.rdata = clint.rdata;
      cpu.error = clint.error;
      cpu.ready = 1'b1;
    end else if (error_ready) begin
      cpu.error = 1'b1;
      cpu.ready = 1'b1;
    end
  end

endmodule

// File: source/bram.sv
`timescale 1ns/1ps

module bram (
  input logic clock,
  input logic reset,
  mem_bus_if.slave bus
);

  import soc_pkg::*;

  logic [data_width-1:0] mem [bram_depth];
  logic [bram_index_width-1:0] index;
  logic accept;

  assign index = bus.addr[bram_index_width+1:2];  // word address
  assign accept = bus.valid && !bus.ready;
  assign bus.error = 1'b0;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= accept;
    end
  end

  // byte lanes written in the accept cycle, read returns the old word
  always_ff @(posedge clock) begin
    if (accept) begin
      for (int i = 0; i < strb_width; i++) begin
        if (bus.wstrb[i]) begin
          mem[index][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      bus.rdata <= mem[index];
    end
  end

endmodule

// File: source/clint.sv
`timescale 1ns/1ps

module clint (
  input logic clock,
  input logic reset,
  mem_bus_if.slave bus,
  output logic msip,
  output logic mtip,
  output logic [63:0] mtime
);

  import soc_pkg::*;

  logic [63:0] mtimecmp;
  logic accept;
  logic write;

  function automatic logic [data_width-1:0] merge_bytes(
    input logic [data_width-1:0] old_word,
    input logic [data_width-1:0] new_word,
    input logic [strb_width-1:0] strb
  );
    logic [data_width-1:0] result;
    result = old_word;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign accept = bus.valid && !bus.ready;
  assign write = accept && (|bus.wstrb);
  assign bus.error = 1'b0;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      bus.ready <= 1'b0;
      msip <= 1'b0;
      mtip <= 1'b0;
      mtime <= '0;
      mtimecmp <= '1;  // no timer interrupt until software sets a compare
    end else begin
      bus.ready <= accept;
      mtime <= mtime + 64'd1;
      mtip <= (mtime >= mtimecmp);
      if (write) begin
        case (bus.addr)
          clint_msip_off: if (bus.wstrb[0]) msip <= bus.wdata[0];
          clint_mtimecmp_off:
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], bus.wdata, bus.wstrb);
          clint_mtimecmp_off + 32'd4:
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], bus.wdata, bus.wstrb);
          default: ;  // mtime is read-only
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      case (bus.addr)
        clint_msip_off: bus.rdata <= {31'd0, msip};
        clint_mtimecmp_off: bus.rdata <= mtimecmp[31:0];
        clint_mtimecmp_off + 32'd4: bus.rdata <= mtimecmp[63:32];
        clint_mtime_off: bus.rdata <= mtime[31:0];
        clint_mtime_off + 32'd4: bus.rdata <= mtime[63:32];
        default: bus.rdata <= '0;
      endcase
    end
  end

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input logic clock,
  input logic reset,
  mem_bus_if.slave imemory,
  mem_bus_if.slave dmemory,
  mem_bus_if.master bus
);

  logic owner_valid;  // a master holds the bus
  logic owner_data;  // 1 when dmemory is the owner
  logic grant_data;

  // data port wins on an idle bus
  always_comb begin
    if (owner_valid) begin
      grant_data = owner_data;
    end else begin
      grant_data = dmemory.valid;
    end
  end

  always_comb begin
    if (grant_data) begin
      bus.valid = dmemory.valid;
      bus.instr = dmemory.instr;
      bus.addr = dmemory.addr;
      bus.wdata = dmemory.wdata;
      bus.wstrb = dmemory.wstrb;
    end else begin
      bus.valid = imemory.valid;
      bus.instr = imemory.instr;
      bus.addr = imemory.addr;
      bus.wdata = imemory.wdata;
      bus.wstrb = imemory.wstrb;
    end
  end

  // response only reaches the owner
  always_comb begin
    dmemory.rdata = bus.rdata;
    dmemory.error = bus.error;
    dmemory.ready = bus.ready && grant_data;
    imemory.rdata = bus.rdata;
    imemory.error = bus.error;
    imemory.ready = bus.ready && !grant_data;
  end

  // lock the choice from the first valid cycle until ready
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      owner_valid <= 1'b0;
      owner_data <= 1'b0;
    end else if (bus.ready) begin
      owner_valid <= 1'b0;  // re-arbitrate next cycle
    end else if (bus.valid && !owner_valid) begin
      owner_valid <= 1'b1;
      owner_data <= grant_data;
    end
  end

endmodule

// File: source/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

  import soc_pkg::*;

  logic valid;
  logic instr;  // request is an instruction fetch
  logic [addr_width-1:0] addr;
  logic [data_width-1:0] wdata;
  logic [strb_width-1:0] wstrb;  // zero for a read
  logic [data_width-1:0] rdata;
  logic error;
  logic ready;  // one-cycle response pulse

  modport master (
    output valid, instr, addr, wdata, wstrb,
    input rdata, error, ready
  );

  modport slave (
    input valid, instr, addr, wdata, wstrb,
    output rdata, error, ready
  );

endinterface

// File: source/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem (
  input logic clock,
  input logic reset,
  input logic imemory_valid,
  input logic imemory_instr,
  input logic [soc_pkg::addr_width-1:0] imemory_addr,
  input logic [soc_pkg::data_width-1:0] imemory_wdata,
  input logic [soc_pkg::strb_width-1:0] imemory_wstrb,
  output logic [soc_pkg::data_width-1:0] imemory_rdata,
  output logic imemory_error,
  output logic imemory_ready,
  input logic dmemory_valid,
  input logic dmemory_instr,
  input logic [soc_pkg::addr_width-1:0] dmemory_addr,
  input logic [soc_pkg::data_width-1:0] dmemory_wdata,
  input logic [soc_pkg::strb_width-1:0] dmemory_wstrb,
  output logic [soc_pkg::data_width-1:0] dmemory_rdata,
  output logic dmemory_error,
  output logic dmemory_ready,
  output logic msip,
  output logic mtip,
  output logic [63:0] mtime,
  output logic print_valid,
  output logic [7:0] print_data
);

  mem_bus_if imem_bus ();
  mem_bus_if dmem_bus ();
  mem_bus_if arb_bus ();
  mem_bus_if bram_bus ();
  mem_bus_if print_bus ();
  mem_bus_if clint_bus ();

  assign imem_bus.valid = imemory_valid;
  assign imem_bus.instr = imemory_instr;
  assign imem_bus.addr = imemory_addr;
  assign imem_bus.wdata = imemory_wdata;
  assign imem_bus.wstrb = imemory_wstrb;
  assign imemory_rdata = imem_bus.rdata;
  assign imemory_error = imem_bus.error;
  assign imemory_ready = imem_bus.ready;

  assign dmem_bus.valid = dmemory_valid;
  assign dmem_bus.instr = dmemory_instr;
  assign dmem_bus.addr = dmemory_addr;
  assign dmem_bus.wdata = dmemory_wdata;
  assign dmem_bus.wstrb = dmemory_wstrb;
  assign dmemory_rdata = dmem_bus.rdata;
  assign dmemory_error = dmem_bus.error;
  assign dmemory_ready = dmem_bus.ready;

  mem_arbiter arbiter_comp (
    .clock (clock),
    .reset (reset),
    .imemory (imem_bus.slave),
    .dmemory (dmem_bus.slave),
    .bus (arb_bus.master)
  );

  addr_decoder decoder_comp (
    .clock (clock),
    .reset (reset),
    .cpu (arb_bus.slave),
    .bram (bram_bus.master),
    .print (print_bus.master),
    .clint (clint_bus.master)
  );

  bram bram_comp (
    .clock (clock),
    .reset (reset),
    .bus (bram_bus.slave)
  );

  print_port print_comp (
    .clock (clock),
    .reset (reset),
    .bus (print_bus.slave),
    .print_valid (print_valid),
    .print_data (print_data)
  );

  clint clint_comp (
    .clock (clock),
    .reset (reset),
    .bus (clint_bus.slave),
    .msip (msip),
    .mtip (mtip),
    .mtime (mtime)
  );

endmodule

// File: source/print_port.sv
`timescale 1ns/1ps

module print_port (
  input logic clock,
  input logic reset,
  mem_bus_if.slave bus,
  output logic print_valid,
  output logic [7:0] print_data
);

  logic accept;
  logic char_write;

  assign accept = bus.valid && !bus.ready;
  assign char_write = accept && bus.wstrb[0];  // only the low byte carries a character
  assign bus.rdata = '0;
  assign bus.error = 1'b0;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      bus.ready <= 1'b0;
      print_valid <= 1'b0;
    end else begin
      bus.ready <= accept;
      print_valid <= char_write;  // lines up with ready
    end
  end

  always_ff @(posedge clock) begin
    if (char_write) begin
      print_data <= bus.wdata[7:0];
    end
  end

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = 4;

  // block ram, 16 KiB
  localparam logic [addr_width-1:0] bram_base_addr = 32'h0000_0000;
  localparam logic [addr_width-1:0] bram_top_addr = 32'h0000_4000;
  localparam int bram_depth = 4096;
  localparam int bram_index_width = $clog2(bram_depth);  // word index bits

  // core-local interruptor
  localparam logic [addr_width-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [addr_width-1:0] clint_top_addr = 32'h0201_0000;

  // character print port
  localparam logic [addr_width-1:0] print_base_addr = 32'h1000_0000;
  localparam logic [addr_width-1:0] print_top_addr = 32'h1000_0010;

  // clint register offsets, relative to clint_base_addr
  localparam logic [addr_width-1:0] clint_msip_off = 32'h0000_0000;  // bit 0 only
  localparam logic [addr_width-1:0] clint_mtimecmp_off = 32'h0000_4000;  // high word at +4
  localparam logic [addr_width-1:0] clint_mtime_off = 32'h0000_bff8;  // read-only, high at +4

endpackage

// File: tb/tb_memory_subsystem.sv
`timescale 1ns/1ps

module tb_memory_subsystem;

  import soc_pkg::*;

  localparam int clock_period = 8;
  localparam int drive_delay = 1;
  localparam int request_limit = 20;
  localparam int watchdog_cycles = 600;  // about three times what the tests take
  localparam int ram_words = 16;

  logic clock;
  logic reset;
  logic imemory_valid;
  logic imemory_instr;
  logic [addr_width-1:0] imemory_addr;
  logic [data_width-1:0] imemory_wdata;
  logic [strb_width-1:0] imemory_wstrb;
  logic [data_width-1:0] imemory_rdata;
  logic imemory_error;
  logic imemory_ready;
  logic dmemory_valid;
  logic dmemory_instr;
  logic [addr_width-1:0] dmemory_addr;
  logic [data_width-1:0] dmemory_wdata;
  logic [strb_width-1:0] dmemory_wstrb;
  logic [data_width-1:0] dmemory_rdata;
  logic dmemory_error;
  logic dmemory_ready;
  logic msip;
  logic mtip;
  logic [63:0] mtime;
  logic print_valid;
  logic [7:0] print_data;

  logic [31:0] lcg_state;
  logic [31:0] ram_model [int];  // word index to expected contents
  int ram_index [ram_words];
  logic [7:0] printed [$];
  int latency [2];  // cycles to ready with dmemory at index 1
  logic [63:0] tick_count;  // clocks since reset was released

  memory_subsystem uut (.*);

  always #(clock_period / 2) clock = ~clock;

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string test_name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s expected %0h actual %0h", test_name, expected, actual);
      stop_run();
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // starts and ends at drive_delay after a rising edge
  task automatic bus_access(input bit use_data, input logic instr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata, output logic error);
    int cycles;
    logic ready;
    cycles = 0;
    ready = 1'b0;
    if (use_data) begin
      dmemory_instr = instr;
      dmemory_addr = addr;
      dmemory_wdata = wdata;
      dmemory_wstrb = wstrb;
      dmemory_valid = 1'b1;
    end else begin
      imemory_instr = instr;
      imemory_addr = addr;
      imemory_wdata = wdata;
      imemory_wstrb = wstrb;
      imemory_valid = 1'b1;
    end
    while (!ready) begin
      @(posedge clock);
      #drive_delay;
      cycles++;
      ready = use_data ? dmemory_ready : imemory_ready;
      if (!ready && cycles >= request_limit) begin
        $display("request to address %h got no ready within %0d cycles", addr, request_limit);
        stop_run();
      end
    end
    rdata = use_data ? dmemory_rdata : imemory_rdata;
    error = use_data ? dmemory_error : imemory_error;
    latency[use_data] = cycles;
    @(posedge clock);  // valid stays up through the ready cycle
    #drive_delay;
    if (use_data) begin
      dmemory_valid = 1'b0;
      dmemory_wstrb = '0;
    end else begin
      imemory_valid = 1'b0;
      imemory_wstrb = '0;
    end
  endtask

  task automatic bus_write(input bit use_data, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wstrb);
    logic [31:0] rdata;
    logic error;
    bus_access(use_data, 1'b0, addr, wdata, wstrb, rdata, error);
    check_value("write error", 0, error);
  endtask

  task automatic bus_read(input bit use_data, input logic instr, input logic [31:0] addr,
                          output logic [31:0] rdata, output logic error);
    bus_access(use_data, instr, addr, '0, '0, rdata, error);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #drive_delay;
  endtask

  // free-running count that mtime has to follow
  always @(posedge clock) begin
    if (!reset) begin
      tick_count <= '0;
    end else begin
      tick_count <= tick_count + 64'd1;
    end
  end

  // collects every character strobe
  always begin
    @(posedge clock);
    #drive_delay;
    if (reset && print_valid) begin
      printed.push_back(print_data);
    end
  end

  dmemory_handshake: assert property (
    @(posedge clock) disable iff (!reset) dmemory_ready |-> dmemory_valid
  ) else begin
    $display("dmemory ready was high while dmemory valid was low");
    stop_run();
  end

  imemory_handshake: assert property (
    @(posedge clock) disable iff (!reset) imemory_ready |-> imemory_valid
  ) else begin
    $display("imemory ready was high while imemory valid was low");
    stop_run();
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    stop_run();
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] data_word;
    logic error;
    logic [3:0] strb;
    logic [63:0] target;
    logic [63:0] expected_time;
    int idx;
    int slot;
    string message;
    clock = 1'b0;
    reset = 1'b0;
    imemory_valid = 1'b0;
    imemory_instr = 1'b0;
    imemory_addr = '0;
    imemory_wdata = '0;
    imemory_wstrb = '0;
    dmemory_valid = 1'b0;
    dmemory_instr = 1'b0;
    dmemory_addr = '0;
    dmemory_wdata = '0;
    dmemory_wstrb = '0;
    lcg_state = 32'd3314;
    repeat (4) @(posedge clock);
    #drive_delay;
    reset = 1'b1;
    next_cycle();

    // ram gets full words and partial strobes and is read back by fetches
    for (int i = 0; i < ram_words; i++) begin
      ram_index[i] = next_random() >> 20;  // 12-bit word index
      data_word = next_random();
      ram_model[ram_index[i]] = data_word;
      bus_write(1'b1, bram_base_addr + ram_index[i] * 4, data_word, 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      slot = (next_random() >> 16) % ram_words;
      strb = 4'((next_random() >> 16) % 15 + 1);
      data_word = next_random();
      idx = ram_index[slot];
      ram_model[idx] = apply_strobes(ram_model[idx], data_word, strb);
      bus_write(1'b1, bram_base_addr + idx * 4, data_word, strb);
    end
    for (int i = 0; i < ram_words; i++) begin
      bus_read(1'b0, 1'b1, bram_base_addr + ram_index[i] * 4, rdata, error);
      check_value("ram readback", ram_model[ram_index[i]], rdata);
      check_value("ram read error", 0, error);
    end

    // error responses
    bus_read(1'b1, 1'b0, 32'h3000_0000, rdata, error);
    check_value("unmapped error", 1, error);
    check_value("unmapped rdata", 0, rdata);
    check_value("unmapped latency", 1, latency[1]);
    bus_read(1'b0, 1'b1, print_base_addr, rdata, error);
    check_value("fetch from print error", 1, error);
    check_value("fetch from print rdata", 0, rdata);
    bus_read(1'b1, 1'b0, bram_base_addr + ram_index[0] * 4, rdata, error);
    check_value("access after error", ram_model[ram_index[0]], rdata);
    check_value("access after error flag", 0, error);
    check_value("access after error latency", 1, latency[1]);

    // print port
    message = "RISCV";
    printed.delete();
    for (int i = 0; i < message.len(); i++) begin
      data_word = next_random();
      data_word[7:0] = message[i];  // upper bytes are noise
      bus_write(1'b1, print_base_addr, data_word, 4'b0001);
    end
    next_cycle();
    next_cycle();
    check_value("print count", message.len(), printed.size());
    for (int i = 0; i < message.len(); i++) begin
      check_value("print character", message[i], printed[i]);
    end

    // clint msip
    bus_write(1'b1, clint_base_addr + clint_msip_off, 32'h1, 4'hf);
    check_value("msip set", 1, msip);
    bus_read(1'b1, 1'b0, clint_base_addr + clint_msip_off, rdata, error);
    check_value("msip set readback", 1, rdata);
    bus_write(1'b1, clint_base_addr + clint_msip_off, 32'h0, 4'hf);
    check_value("msip clear", 0, msip);
    bus_read(1'b1, 1'b0, clint_base_addr + clint_msip_off, rdata, error);
    check_value("msip clear readback", 0, rdata);

    // clint timer compare
    bus_read(1'b1, 1'b0, clint_base_addr + clint_mtime_off, rdata, error);
    expected_time = tick_count - 64'd2;  // count at the accept edge
    target[31:0] = rdata;
    bus_read(1'b1, 1'b0, clint_base_addr + clint_mtime_off + 4, rdata, error);
    target[63:32] = rdata;
    check_value("mtime read", expected_time, target);
    target = target + 64'd50;
    bus_write(1'b1, clint_base_addr + clint_mtimecmp_off, target[31:0], 4'hf);
    bus_write(1'b1, clint_base_addr + clint_mtimecmp_off + 4, target[63:32], 4'hf);
    while (mtime < target) begin
      check_value("mtip before compare", 0, mtip);
      check_value("mtime count", tick_count, mtime);
      next_cycle();
    end
    next_cycle();
    check_value("mtip after compare", 1, mtip);
    bus_write(1'b1, clint_base_addr + clint_mtimecmp_off, 32'hffff_ffff, 4'hf);
    bus_write(1'b1, clint_base_addr + clint_mtimecmp_off + 4, 32'hffff_ffff, 4'hf);
    next_cycle();
    check_value("mtip cleared", 0, mtip);

    // data wins when both masters request in the same cycle
    data_word = next_random();
    idx = ram_index[1];
    ram_model[idx] = data_word;
    fork
      bus_write(1'b1, bram_base_addr + idx * 4, data_word, 4'hf);
      bus_read(1'b0, 1'b1, bram_base_addr + idx * 4, rdata, error);
    join
    check_value("arbitration data latency", 1, latency[1]);
    check_value("arbitration fetch latency", 3, latency[0]);  // owner ready plus 2
    check_value("arbitration fetch data", ram_model[idx], rdata);
    check_value("arbitration fetch error", 0, error);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: vlog.f
source/soc_pkg.sv
source/mem_bus_if.sv
source/mem_arbiter.sv
source/addr_decoder.sv
source/bram.sv
source/print_port.sv
source/clint.sv
source/memory_subsystem.sv
tb/tb_memory_subsystem.sv
